// ==== project.f ====
aes_pkg.sv
aes_ifs.sv
aes_key_expand.sv
aes_state_round.sv
aes_core.sv
aes_wb_regs.sv
aes_accel_top.sv
tb_aes_accel.sv

// ==== Makefile ====
# Verilator simulation of the AES-128 accelerator testbench
VERILATOR ?= verilator
TOP       ?= tb_aes_accel
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^NO ERRORS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_aes_accel.sv ====
// Testbench for the AES-128 Wishbone accelerator, runs FIPS-197 jobs and register checks on the top
`timescale 1ns/100ps

module tb_aes_accel;
  import aes_pkg::WB_ADR_W;
  import aes_pkg::WB_DAT_W;
  import aes_pkg::NUM_ROUNDS;
  import aes_pkg::ADDR_KEY0;
  import aes_pkg::ADDR_PT0;
  import aes_pkg::ADDR_CTRL;
  import aes_pkg::ADDR_STAT;
  import aes_pkg::ADDR_CT0;

  // Inputs change this long after a rising edge, outputs are sampled at the same offset
  localparam int DRV_DELAY  = 10;
  localparam int ACK_LIMIT  = 8;
  localparam int POLL_LIMIT = 20;
  // Five jobs of about 40 accesses, each access about 5 cycles with gaps, doubled for margin
  localparam int MAX_CYCLES = 5 * 40 * 5 * 2;
  localparam logic [WB_ADR_W-1:0] UNUSED_ADR = 6'h28;

  // FIPS-197 Appendix C.1 and Appendix B vectors
  localparam logic [127:0] KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] PT_C1  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [127:0] KEY_B  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] PT_B   = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] CT_B   = 128'h3925841d02dc09fbdc118597196a0b32;

  logic                clk;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [3:0]          wb_sel;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_ack;

  int          check_count = 0;
  int          mismatch_count = 0;
  int          failure_count = 0;
  int          assert_fail_count = 0;
  int          cycle_count = 0;
  bit          gaps_on = 1'b1;
  logic [31:0] lfsr_q = 32'h1e91;

  aes_accel_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Ack must answer a request that was already there and never repeat on the next cycle
  a_ack_handshake: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb) && !$past(wb_ack))
    else begin
      assert_fail_count++;
      $display("wb_ack at %0t did not follow a fresh request", $time);
    end

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h8020_0003 : 32'h0000_0000);
    return out;
  endfunction

  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // GF(2^8) product with the AES polynomial, shift and add
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] aa;
    p = 8'h00;
    aa = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ aa;
      end
      aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // S-box from its definition, the inverse is a^254 and then the affine map
  function automatic logic [7:0] sub_byte(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] s;
    inv = 8'h01;
    for (int i = 0; i < 254; i++) begin
      inv = gf_mul(inv, a);
    end
    s = inv ^ 8'h63;
    for (int k = 1; k < 5; k++) begin
      s = s ^ ((inv << k) | (inv >> (8 - k)));
    end
    return s;
  endfunction

  // Reference AES-128 encryption, bytes in FIPS-197 order with byte i in row i%4 of column i/4
  function automatic logic [127:0] aes_encrypt(input logic [127:0] key, input logic [127:0] pt);
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [31:0]  w [4];
    logic [31:0]  rot;
    logic [7:0]   rcon;
    logic [127:0] out;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127-32*i -: 32];
    end
    for (int i = 0; i < 16; i++) begin
      s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];
    end
    for (int r = 1; r <= NUM_ROUNDS; r++) begin
      rot = {sub_byte(w[3][23:16]), sub_byte(w[3][15:8]),
             sub_byte(w[3][7:0]), sub_byte(w[3][31:24])} ^ {rcon, 24'h000000};
      w[0] = w[0] ^ rot;
      w[1] = w[1] ^ w[0];
      w[2] = w[2] ^ w[1];
      w[3] = w[3] ^ w[2];
      rcon = gf_mul(rcon, 8'h02);
      // Row q of column c comes from column c+q
      for (int i = 0; i < 16; i++) begin
        t[i] = sub_byte(s[(i % 4) + 4 * (((i / 4) + (i % 4)) % 4)]);
      end
      for (int c = 0; c < 4; c++) begin
        for (int q = 0; q < 4; q++) begin
          if (r == NUM_ROUNDS) begin
            s[4*c+q] = t[4*c+q];
          end else begin
            s[4*c+q] = gf_mul(t[4*c+q], 8'h02) ^ gf_mul(t[4*c+(q+1)%4], 8'h03)
                       ^ t[4*c+(q+2)%4] ^ t[4*c+(q+3)%4];
          end
        end
      end
      for (int i = 0; i < 16; i++) begin
        s[i] = s[i] ^ w[i/4][31-8*(i%4) -: 8];
      end
    end
    for (int i = 0; i < 16; i++) begin
      out[127-8*i -: 8] = s[i];
    end
    return out;
  endfunction

  function automatic logic [WB_ADR_W-1:0] word_adr(input logic [WB_ADR_W-1:0] base,
                                                  input logic [1:0] idx);
    return base + {2'b00, idx, 2'b00};
  endfunction

  // Bytes with their select bit set take the new value, the rest keep the old one
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return m;
  endfunction

  task automatic expect_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // One classic Wishbone access, the request stays up through the ack cycle
  task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WB_DAT_W-1:0] wdata, input logic [3:0] sel,
                           output logic [WB_DAT_W-1:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    if (gaps_on) begin
      repeat (lfsr_take(2)) @(posedge clk);
    end
    @(posedge clk);
    #DRV_DELAY;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    wb_sel   = sel;
    do begin
      @(posedge clk);
      #DRV_DELAY;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      failure_count++;
      $display("no wb_ack within %0d cycles for the access at address %h", ACK_LIMIT, adr);
    end
    @(posedge clk);
    #DRV_DELAY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data,
                          input logic [3:0] sel);
    logic [WB_DAT_W-1:0] ignored;
    bus_cycle(1'b1, adr, data, sel, ignored);
  endtask

  task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
    bus_cycle(1'b0, adr, '0, 4'hf, data);
  endtask

  task automatic poll_done();
    logic [WB_DAT_W-1:0] stat;
    int                  polls;
    stat = '0;
    polls = 0;
    while (!stat[1] && polls < POLL_LIMIT) begin
      wb_read(ADDR_STAT, stat);
      polls++;
    end
    if (!stat[1]) begin
      failure_count++;
      $display("status done bit never set after %0d polls", polls);
    end
  endtask

  // Loads a job, starts it and checks the ciphertext, split writes the key in two byte halves
  task automatic run_job(input string name, input logic [127:0] key, input logic [127:0] pt,
                         input logic [127:0] exp, input bit split, input bit restart);
    logic [WB_DAT_W-1:0] got;
    logic [3:0]          sel;
    for (int i = 0; i < 4; i++) begin
      sel = 4'hf;
      if (split) begin
        sel = 4'(lfsr_take(4));
      end
      wb_write(word_adr(ADDR_KEY0, 2'(i)), key[127-32*i -: 32], sel);
      if (split) begin
        wb_write(word_adr(ADDR_KEY0, 2'(i)), key[127-32*i -: 32], ~sel);
      end
      wb_write(word_adr(ADDR_PT0, 2'(i)), pt[127-32*i -: 32], 4'hf);
    end
    // No idle gaps around a restart so the second start surely lands while busy
    gaps_on = !restart;
    wb_write(ADDR_CTRL, 32'h1, 4'hf);
    if (restart) begin
      wb_read(ADDR_STAT, got);
      expect_word({name, " status after start"}, got, 32'h1);
      wb_write(ADDR_CTRL, 32'h1, 4'hf);
      // The first job ends 11 cycles after its start ack, a restarted one would still be busy
      repeat (3) @(posedge clk);
      wb_read(ADDR_STAT, got);
      expect_word({name, " status after dropped start"}, got, 32'h2);
    end
    gaps_on = 1'b1;
    poll_done();
    for (int i = 0; i < 4; i++) begin
      wb_read(word_adr(ADDR_CT0, 2'(i)), got);
      expect_word({name, " ciphertext"}, got, exp[127-32*i -: 32]);
    end
  endtask

  initial begin
    logic [WB_DAT_W-1:0] got;
    logic [WB_DAT_W-1:0] first;
    logic [WB_DAT_W-1:0] second;
    logic [3:0]          sel;
    logic [WB_ADR_W-1:0] adr;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = 4'h0;
    repeat (2) @(posedge clk);
    #DRV_DELAY;
    rst_n = 1'b1;

    run_job("C.1", KEY_C1, PT_C1, CT_C1, 1'b0, 1'b0);

    // Full write then a partial overwrite of every key and plaintext word
    for (int g = 0; g < 2; g++) begin
      for (int i = 0; i < 4; i++) begin
        adr = word_adr((g == 0) ? ADDR_KEY0 : ADDR_PT0, 2'(i));
        first = lfsr_take(32);
        second = lfsr_take(32);
        sel = 4'(lfsr_take(4));
        wb_write(adr, first, 4'hf);
        wb_write(adr, second, sel);
        wb_read(adr, got);
        expect_word("key or plaintext readback", got, merge_bytes(first, second, sel));
      end
    end
    // Result and status registers belong to the core and ignore host writes
    for (int i = 0; i < 4; i++) begin
      wb_write(word_adr(ADDR_CT0, 2'(i)), 32'hffff_ffff, 4'hf);
      wb_read(word_adr(ADDR_CT0, 2'(i)), got);
      expect_word("ciphertext after host write", got, CT_C1[127-32*i -: 32]);
    end
    wb_write(ADDR_STAT, 32'hffff_ffff, 4'hf);
    wb_read(ADDR_STAT, got);
    expect_word("status after host write", got, 32'h2);
    wb_read(UNUSED_ADR, got);
    expect_word("unused address", got, 32'h0);

    run_job("B", KEY_B, PT_B, CT_B, 1'b1, 1'b1);
    run_job("B plaintext under C.1 key", KEY_C1, PT_B, aes_encrypt(KEY_C1, PT_B), 1'b0, 1'b0);
    run_job("C.1 plaintext under B key", KEY_B, PT_C1, aes_encrypt(KEY_B, PT_C1), 1'b1, 1'b0);

    $display("checks %0d, mismatches %0d, other failures %0d", check_count, mismatch_count,
             failure_count + assert_fail_count);
    if (mismatch_count == 0 && failure_count + assert_fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Run limit, a stuck handshake ends here
  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("checks %0d, mismatches %0d, other failures %0d", check_count, mismatch_count,
             failure_count + assert_fail_count + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== aes_accel_top.sv ====
// Top level of the AES-128 accelerator, a Wishbone slave that wraps the register file and core
`timescale 1ns/100ps

module aes_accel_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [aes_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [aes_pkg::WB_DAT_W-1:0] wb_dat_w,
  input  logic [3:0]                   wb_sel,
  output logic [aes_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack
);

  // One job channel joins the host registers and the cipher engine
  aes_job_if job_if ();

  aes_wb_regs uu_aes_wb_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .job      (job_if)
  );

  aes_core uu_aes_core (
    .clk   (clk),
    .rst_n (rst_n),
    .job   (job_if)
  );

endmodule

// ==== aes_wb_regs.sv ====
// Wishbone classic slave register file that feeds key and plaintext to the core and holds results
`timescale 1ns/100ps

module aes_wb_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [aes_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [aes_pkg::WB_DAT_W-1:0] wb_dat_w,
  input  logic [3:0]                   wb_sel,
  output logic [aes_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack,
  aes_job_if.regs                      job
);
  import aes_pkg::*;

  reg_sel_e            reg_sel;
  logic [1:0]          word;
  logic                pending;
  logic                wr_acc;
  logic                done_q;
  logic [WB_DAT_W-1:0] key_w [4];
  logic [WB_DAT_W-1:0] pt_w  [4];
  logic [WB_DAT_W-1:0] ct_w  [4];

  // Group decode on the upper address bits, the word index sits in bits 3:2
  assign word = wb_adr[3:2];

  always_comb begin
    reg_sel = SEL_NONE;
    if (wb_adr[5:4] == ADDR_KEY0[5:4]) begin
      reg_sel = SEL_KEY;
    end else if (wb_adr[5:4] == ADDR_PT0[5:4]) begin
      reg_sel = SEL_PT;
    end else if (wb_adr[5:4] == ADDR_CT0[5:4]) begin
      reg_sel = SEL_CT;
    end else if (wb_adr[5:2] == ADDR_CTRL[5:2]) begin
      reg_sel = SEL_CTRL;
    end else if (wb_adr[5:2] == ADDR_STAT[5:2]) begin
      reg_sel = SEL_STAT;
    end
  end

  // Ack one cycle after the access is seen, never back to back
  assign pending = wb_cyc && wb_stb;
  assign wr_acc  = wb_ack && pending && wb_we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= pending && !wb_ack;
    end
  end

  // Start is only raised while the core is idle, so a start during a job is dropped here
  assign job.start    = wr_acc && (reg_sel == SEL_CTRL) && wb_dat_w[0] && !job.busy;
  assign job.key      = {key_w[0], key_w[1], key_w[2], key_w[3]};
  assign job.block_in = {pt_w[0], pt_w[1], pt_w[2], pt_w[3]};

  // Key and plaintext words take byte-enabled writes on the ack cycle
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (wr_acc && wb_sel[b] && reg_sel == SEL_KEY) begin
        key_w[word][8*b +: 8] <= wb_dat_w[8*b +: 8];
      end
      if (wr_acc && wb_sel[b] && reg_sel == SEL_PT) begin
        pt_w[word][8*b +: 8] <= wb_dat_w[8*b +: 8];
      end
    end
    // Ciphertext only ever comes from the core
    if (job.done_pulse) begin
      for (int w = 0; w < 4; w++) begin
        ct_w[w] <= job.block_out[127-32*w -: 32];
      end
    end
  end

  // Sticky done flag, cleared by the next accepted start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (job.start) begin
      done_q <= 1'b0;
    end else if (job.done_pulse) begin
      done_q <= 1'b1;
    end
  end

  // Read data follows the address and is sampled by the master during ack
  always_comb begin
    case (reg_sel)
      SEL_KEY:  wb_dat_r = key_w[word];
      SEL_PT:   wb_dat_r = pt_w[word];
      SEL_STAT: wb_dat_r = {{(WB_DAT_W-2){1'b0}}, done_q, job.busy};
      SEL_CT:   wb_dat_r = ct_w[word];
      default:  wb_dat_r = '0;
    endcase
  end

  a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> $past(pending))
    else $error("wb_ack without a pending access");

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high on two consecutive cycles");

endmodule

// ==== aes_core.sv ====
// Iterative AES-128 cipher core, one round per clock with the key schedule beside it
`timescale 1ns/100ps

module aes_core (
  input logic     clk,
  input logic     rst_n,
  aes_job_if.core job
);
  import aes_pkg::*;

  aes_state_e         state_q;
  logic [3:0]         round_q;
  logic [BLOCK_W-1:0] cipher_q;
  logic [BLOCK_W-1:0] round_out;
  logic [BLOCK_W-1:0] round_result;
  logic               accept;
  logic               final_round;

  aes_key_if key_if ();

  // A start is taken only from idle, which also restarts the key schedule
  assign accept       = job.start && (state_q == ST_IDLE);
  assign final_round  = (state_q == ST_ROUND) && (round_q == 4'(NUM_ROUNDS));
  assign key_if.load  = accept;
  assign key_if.step  = (state_q == ST_ROUND);
  assign key_if.key   = job.key;

  // AddRoundKey joins the state half and the key half of the round
  assign round_result = round_out ^ key_if.next_key;

  // The result is visible in the same cycle as done_pulse so the register file can latch it
  assign job.busy       = (state_q == ST_ROUND);
  assign job.done_pulse = final_round;
  assign job.block_out  = round_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      round_q <= 4'd0;
    end else begin
      case (state_q)
        ST_IDLE: if (accept) begin
          state_q <= ST_ROUND;
          round_q <= 4'd1;
        end
        ST_ROUND: if (final_round) begin
          state_q <= ST_IDLE;
          round_q <= 4'd0;
        end else begin
          round_q <= round_q + 4'd1;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Initial AddRoundKey on start, then one full round per cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      cipher_q <= job.block_in ^ job.key;
    end else if (state_q == ST_ROUND) begin
      cipher_q <= round_result;
    end
  end

  aes_key_expand uu_key_expand (
    .clk      (clk),
    .rst_n    (rst_n),
    .key_port (key_if)
  );

  aes_state_round uu_state_round (
    .state_in    (cipher_q),
    .final_round (final_round),
    .state_out   (round_out)
  );

  // Done comes only at the end of a full run of rounds
  a_done_final: assert property (@(posedge clk) disable iff (!rst_n)
    (job.busy && job.done_pulse) |-> final_round && $past(job.busy, NUM_ROUNDS - 1))
    else $error("done_pulse outside the final round");

  // The register file is expected to filter starts while the core runs
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    job.start |-> !job.busy)
    else $error("start arrived while the core was busy");

  a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    job.done_pulse |=> !job.done_pulse)
    else $error("done_pulse held for more than one cycle");

endmodule

// ==== aes_state_round.sv ====
// Combinational state half of one AES round: SubBytes, ShiftRows and optional MixColumns
`timescale 1ns/100ps

module aes_state_round (
  input  logic [127:0] state_in,
  input  logic         final_round,
  output logic [127:0] state_out
);
  import aes_pkg::*;

  // Bytes are numbered in FIPS-197 order, byte i is row i%4 of column i/4
  logic [7:0] sb [16];
  logic [7:0] sr [16];
  logic [7:0] mc [16];

  // SubBytes and ShiftRows, row r rotates left by r columns
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      sb[i] = sbox_table[state_in[127-8*i -: 8]];
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr[r+4*c] = sb[r+4*((c+r)%4)];
      end
    end
  end

  // MixColumns, where 3*a is written as xtime(a) ^ a
  always_comb begin
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      a0 = sr[4*c];
      a1 = sr[4*c+1];
      a2 = sr[4*c+2];
      a3 = sr[4*c+3];
      mc[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      mc[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      mc[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      mc[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
  end

  // The last round has no MixColumns step
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      state_out[127-8*i -: 8] = final_round ? sr[i] : mc[i];
    end
  end

endmodule

// ==== aes_key_expand.sv ====
// On-the-fly AES-128 key schedule that holds one round key and hands the next one to the core
`timescale 1ns/100ps

module aes_key_expand (
  input logic       clk,
  input logic       rst_n,
  aes_key_if.keygen key_port
);
  import aes_pkg::*;

  logic [BLOCK_W-1:0] round_key;
  logic [7:0]         rcon;
  logic [31:0]        w0, w1, w2, w3;
  logic [31:0]        temp;

  // Split the held key into its four words with w0 as the most significant
  assign {w0, w1, w2, w3} = round_key;

  // RotWord then SubWord on the last word, with the round constant in the top byte
  assign temp = {sbox_table[w3[23:16]], sbox_table[w3[15:8]],
                 sbox_table[w3[7:0]],   sbox_table[w3[31:24]]} ^ {rcon, 24'h000000};

  // Each new word chains on the one before it
  always_comb begin
    key_port.next_key[127:96] = w0 ^ temp;
    key_port.next_key[95:64]  = w1 ^ w0 ^ temp;
    key_port.next_key[63:32]  = w2 ^ w1 ^ w0 ^ temp;
    key_port.next_key[31:0]   = w3 ^ w2 ^ w1 ^ w0 ^ temp;
  end

  // Load takes the cipher key as round key 0 and each step moves on to the next round key
  always_ff @(posedge clk) begin
    if (key_port.load) begin
      round_key <= key_port.key;
    end else if (key_port.step) begin
      round_key <= key_port.next_key;
    end
  end

  // The round constant restarts at 0x01 on load and doubles in GF(2^8) on every step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rcon <= RCON_INIT;
    end else if (key_port.load) begin
      rcon <= RCON_INIT;
    end else if (key_port.step) begin
      rcon <= xtime(rcon);
    end
  end

  // The core must never restart the schedule in the middle of a round step
  a_load_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(key_port.load && key_port.step))
    else $error("key unit saw load and step together");

endmodule

// ==== aes_ifs.sv ====
// Interfaces between the register file, the cipher core and the key expansion unit
`timescale 1ns/100ps

// Job handoff from the register file to the core and the result coming back
interface aes_job_if;
  import aes_pkg::*;

  logic               start;
  logic [BLOCK_W-1:0] key;
  logic [BLOCK_W-1:0] block_in;
  logic               busy;
  logic               done_pulse;
  logic [BLOCK_W-1:0] block_out;

  modport regs (output start, key, block_in, input busy, done_pulse, block_out);
  modport core (input start, key, block_in, output busy, done_pulse, block_out);
endinterface

// Round key control from the core to the key expansion unit
interface aes_key_if;
  import aes_pkg::*;

  logic               load;
  logic               step;
  logic [BLOCK_W-1:0] key;
  logic [BLOCK_W-1:0] next_key;

  modport core   (output load, step, key, input next_key);
  modport keygen (input load, step, key, output next_key);
endinterface

// ==== aes_pkg.sv ====
// Shared AES-128 constants, S-box, GF helper and register map, imported by every design file
package aes_pkg;

  // Widths of the cipher block and of the Wishbone register bus
  localparam int NUM_ROUNDS = 10;
  localparam int BLOCK_W    = 128;
  localparam int WB_ADR_W   = 6;
  localparam int WB_DAT_W   = 32;

  // Byte addresses of the register map, word 0 of each group holds the most significant bits
  localparam logic [WB_ADR_W-1:0] ADDR_KEY0 = 6'h00;
  localparam logic [WB_ADR_W-1:0] ADDR_PT0  = 6'h10;
  localparam logic [WB_ADR_W-1:0] ADDR_CTRL = 6'h20;
  localparam logic [WB_ADR_W-1:0] ADDR_STAT = 6'h24;
  localparam logic [WB_ADR_W-1:0] ADDR_CT0  = 6'h30;

  // Round constant used by the first key expansion step
  localparam logic [7:0] RCON_INIT = 8'h01;

  // Forward S-box, entry 0 sits in the most significant byte of the concatenation
  localparam logic [0:255][7:0] sbox_table = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Multiply by 2 in GF(2^8) with the AES reduction polynomial x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Core FSM states, the core idles until a start and then runs ten rounds
  typedef enum logic {
    ST_IDLE,
    ST_ROUND
  } aes_state_e;

  // Register groups that a Wishbone word address can select
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_KEY,
    SEL_PT,
    SEL_CTRL,
    SEL_STAT,
    SEL_CT
  } reg_sel_e;

endpackage
